// File: verilog/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// ==========================================================================
// cache geometry
// ==========================================================================

`define CACHE_WAYS 4
`define CACHE_SETS 64
`define CACHE_LINE_BYTES 8
`define CACHE_ADR_W 16

// minimum number of cycles between two update-port requests
`define CACHE_UPD_GAP 4

// address field widths follow from the geometry above
`define CACHE_OFS_W $clog2(`CACHE_LINE_BYTES)
`define CACHE_IDX_W $clog2(`CACHE_SETS)
`define CACHE_TAG_W (`CACHE_ADR_W - `CACHE_IDX_W - `CACHE_OFS_W)

`endif

// File: verilog/cache_pkg.sv
`default_nettype none
`include "cache_settings.svh"

package cache_pkg;

	// byte address and its fields, laid out as tag | index | offset
	typedef logic [`CACHE_ADR_W-1:0] adr_t;
	typedef logic [`CACHE_IDX_W-1:0] index_t;
	typedef logic [`CACHE_TAG_W-1:0] tag_t;

	// one cache line and its byte enables
	typedef logic [`CACHE_LINE_BYTES*8-1:0] line_t;
	typedef logic [`CACHE_LINE_BYTES-1:0] sel_t;

	// a way holds its tag next to the line data
	typedef struct packed {
		tag_t tag;
		line_t data;
	} way_entry_t;

	// all ways of one set form a single RAM word, way 0 in the low bits
	typedef way_entry_t [`CACHE_WAYS-1:0] set_word_t;

	// one bit per way, used for valid and hit vectors
	typedef logic [`CACHE_WAYS-1:0] way_vec_t;

	function automatic index_t adr_index(input adr_t adr);
		return adr[`CACHE_OFS_W +: `CACHE_IDX_W];
	endfunction

	function automatic tag_t adr_tag(input adr_t adr);
		return adr[`CACHE_ADR_W-1 -: `CACHE_TAG_W];
	endfunction

endpackage

`default_nettype wire

// File: verilog/set_ram.sv
`default_nettype none
`include "cache_settings.svh"

module set_ram (
	input wire logic wclk,
	input wire logic we,
	input wire cache_pkg::index_t wr_index,
	input wire cache_pkg::set_word_t wr_word,
	input wire cache_pkg::index_t rd_index,
	output cache_pkg::set_word_t rd_word
);

	import cache_pkg::*;

	// one word per set, every way of the set side by side
	// tags and lines come out of power-up as garbage, the valid bits in
	// valid_array decide whether a way may be used at all
	set_word_t mem [`CACHE_SETS];

	// ======================================================================
	// write port and registered read port
	// ======================================================================

	// a write lands at the strobe edge
	always_ff @(posedge wclk) begin
		if (we)
			mem[wr_index] <= wr_word;
	end

	// read data follows the address edge by one cycle
	// a read and a write to the same set on one edge return the old word
	always_ff @(posedge wclk) begin
		rd_word <= mem[rd_index];
	end

	// the update stage must never write to an unknown set
	a_wr_index_known: assert property (@(posedge wclk) we |-> !$isunknown(wr_index));

endmodule

`default_nettype wire

// File: verilog/valid_array.sv
`default_nettype none
`include "cache_settings.svh"

module valid_array (
	input wire logic wclk,
	input wire logic rst,
	input wire logic ld_we,
	input wire logic hit_we,
	input wire cache_pkg::way_vec_t hit_way,
	input wire cache_pkg::index_t upd_index,
	input wire logic inv,
	input wire cache_pkg::index_t inv_index,
	input wire cache_pkg::index_t rd_index,
	input wire cache_pkg::index_t upd_rd_index,
	output cache_pkg::way_vec_t rd_valid,
	output cache_pkg::way_vec_t upd_valid
);

	import cache_pkg::*;

	// bit w of entry s tells whether way w of set s holds a line
	way_vec_t vbits [`CACHE_SETS];

	// ======================================================================
	// valid bit update
	// ======================================================================

	always_ff @(posedge wclk) begin
		if (rst) begin
			// all sets empty in a single cycle
			for (int s = 0; s < `CACHE_SETS; s++)
				vbits[s] <= '0;
		end else begin
			// a load moves every way down one place and fills way 0
			// whatever sat in the last way drops out
			if (ld_we)
				vbits[upd_index] <= {vbits[upd_index][`CACHE_WAYS-2:0], 1'b1};
			// a write hit leaves its way marked as valid
			if (hit_we)
				vbits[upd_index] <= vbits[upd_index] | hit_way;
			// invalidate comes last so it overrides an update of the same set
			if (inv)
				vbits[inv_index] <= '0;
		end
	end

	// both readers look at the bits without a register in between
	assign rd_valid = vbits[rd_index];
	assign upd_valid = vbits[upd_rd_index];

	// the update stage issues either a load or a write hit, never both
	a_one_cmd: assert property (@(posedge wclk) disable iff (rst) !(ld_we && hit_we));

endmodule

`default_nettype wire

// File: verilog/tag_match.sv
`default_nettype none
`include "cache_settings.svh"

module tag_match (
	input wire logic wclk,
	input wire logic rst,
	input wire logic req,
	input wire cache_pkg::adr_t adr,
	input wire cache_pkg::set_word_t word,
	input wire cache_pkg::way_vec_t valid,
	output logic strobe,
	output cache_pkg::adr_t adr_q,
	output cache_pkg::way_vec_t hit
);

	import cache_pkg::*;

	// first stage, taken on the same edge that starts the RAM read
	logic req_r;
	adr_t adr_r;
	way_vec_t valid_r;
	// per-way compare of the RAM word against the first-stage address
	way_vec_t match;

	always_ff @(posedge wclk) begin
		if (rst) begin
			req_r <= 1'b0;
			strobe <= 1'b0;
			hit <= '0;
		end else begin
			req_r <= req;
			strobe <= req_r;
			hit <= match;
		end
	end

	// adr_r keeps the previous request address, so a request arriving right
	// behind another one does not overwrite the address still being compared
	always_ff @(posedge wclk) begin
		adr_r <= adr;
		valid_r <= valid;
		adr_q <= adr_r;
	end

	always_comb begin
		for (int w = 0; w < `CACHE_WAYS; w++)
			match[w] = valid_r[w] && (word[w].tag == adr_tag(adr_r));
	end

	// a tag is only loaded after it missed, so no set may hold it twice
	a_hit_onehot: assert property (@(posedge wclk) disable iff (rst) $onehot0(hit));

endmodule

`default_nettype wire

// File: verilog/read_port.sv
`default_nettype none
`include "cache_settings.svh"

module read_port (
	input wire logic wclk,
	input wire logic rst,
	input wire logic rd_req,
	input wire cache_pkg::adr_t rd_adr,
	input wire cache_pkg::set_word_t rd_word,
	input wire cache_pkg::way_vec_t rd_valid,
	output cache_pkg::index_t rd_index,
	output logic rd_ack,
	output cache_pkg::line_t rd_dat,
	output logic rd_miss,
	output cache_pkg::adr_t miss_adr
);

	import cache_pkg::*;

	logic strobe;
	adr_t adr_q;
	way_vec_t hit;
	// RAM word delayed one stage so it lines up with its compare result
	set_word_t word_q;
	line_t hit_line;

	// the request index goes straight to the read RAM copy and valid array
	assign rd_index = adr_index(rd_adr);

	tag_match u_match (
		.wclk(wclk),
		.rst(rst),
		.req(rd_req),
		.adr(rd_adr),
		.word(rd_word),
		.valid(rd_valid),
		.strobe(strobe),
		.adr_q(adr_q),
		.hit(hit)
	);

	always_ff @(posedge wclk) begin
		word_q <= rd_word;
	end

	// at most one way hits, so an or over the ways would give the same line
	always_comb begin
		hit_line = '0;
		for (int w = 0; w < `CACHE_WAYS; w++)
			if (hit[w])
				hit_line = word_q[w].data;
	end

	// ======================================================================
	// answer stage, exactly one of ack or miss per request
	// ======================================================================

	always_ff @(posedge wclk) begin
		if (rst) begin
			rd_ack <= 1'b0;
			rd_miss <= 1'b0;
		end else begin
			rd_ack <= strobe && (|hit);
			rd_miss <= strobe && !(|hit);
		end
	end

	always_ff @(posedge wclk) begin
		rd_dat <= hit_line;
		miss_adr <= adr_q;
	end

endmodule

`default_nettype wire

// File: verilog/line_update.sv
`default_nettype none
`include "cache_settings.svh"

module line_update (
	input wire logic wclk,
	input wire logic rst,
	input wire logic ld_req,
	input wire cache_pkg::adr_t ld_adr,
	input wire cache_pkg::line_t ld_dat,
	input wire logic wr_req,
	input wire cache_pkg::adr_t wr_adr,
	input wire cache_pkg::sel_t wr_sel,
	input wire cache_pkg::line_t wr_dat,
	input wire cache_pkg::set_word_t upd_word,
	input wire cache_pkg::way_vec_t upd_valid,
	output cache_pkg::index_t upd_rd_index,
	output logic ram_we,
	output cache_pkg::index_t ram_index,
	output cache_pkg::set_word_t ram_word,
	output logic ld_we,
	output logic hit_we,
	output cache_pkg::way_vec_t hit_way,
	output logic wr_ack
);

	import cache_pkg::*;

	logic upd_req;
	adr_t req_adr;
	// kind of the update in flight, set for a load and clear for a write
	logic is_ld;
	line_t ld_line;
	sel_t wr_sel_q;
	line_t wr_line;
	logic strobe;
	adr_t adr_q;
	way_vec_t hit;
	set_word_t word_q;
	set_word_t next_word;

	// loads and writes share one set lookup
	assign upd_req = ld_req || wr_req;
	assign req_adr = ld_req ? ld_adr : wr_adr;
	assign upd_rd_index = adr_index(req_adr);

	tag_match u_match (
		.wclk(wclk),
		.rst(rst),
		.req(upd_req),
		.adr(req_adr),
		.word(upd_word),
		.valid(upd_valid),
		.strobe(strobe),
		.adr_q(adr_q),
		.hit(hit)
	);

	// ======================================================================
	// request capture
	// ======================================================================

	always_ff @(posedge wclk) begin
		if (rst)
			is_ld <= 1'b0;
		else if (upd_req)
			is_ld <= ld_req;
	end

	// only one update is in flight, so data may sit here until it is written
	always_ff @(posedge wclk) begin
		if (upd_req) begin
			ld_line <= ld_dat;
			wr_sel_q <= wr_sel;
			wr_line <= wr_dat;
		end
		word_q <= upd_word;
	end

	// ======================================================================
	// new set word
	// ======================================================================

	always_comb begin
		next_word = word_q;
		if (is_ld) begin
			// shift ways down one place, the new line takes way 0
			for (int w = `CACHE_WAYS - 1; w > 0; w--)
				next_word[w] = word_q[w-1];
			next_word[0].tag = adr_tag(adr_q);
			next_word[0].data = ld_line;
		end else begin
			// merge the enabled bytes into the hitting way, the tag is unchanged
			for (int w = 0; w < `CACHE_WAYS; w++)
				for (int b = 0; b < `CACHE_LINE_BYTES; b++)
					if (hit[w] && wr_sel_q[b])
						next_word[w].data[b*8 +: 8] = wr_line[b*8 +: 8];
		end
	end

	// write stage, a write miss leaves RAM and valid bits alone
	always_ff @(posedge wclk) begin
		if (rst) begin
			ram_we <= 1'b0;
			ld_we <= 1'b0;
			hit_we <= 1'b0;
			wr_ack <= 1'b0;
		end else begin
			ram_we <= strobe && (is_ld || (|hit));
			ld_we <= strobe && is_ld;
			hit_we <= strobe && !is_ld && (|hit);
			wr_ack <= strobe && !is_ld;
		end
	end

	always_ff @(posedge wclk) begin
		ram_index <= adr_index(adr_q);
		ram_word <= next_word;
		hit_way <= hit;
	end

	// the pipeline holds a single update, so requests must keep their distance
	a_upd_gap: assert property (@(posedge wclk) disable iff (rst)
		upd_req |=> !upd_req [* (`CACHE_UPD_GAP - 1)]);
	a_no_collide: assert property (@(posedge wclk) disable iff (rst) !(ld_req && wr_req));

endmodule

`default_nettype wire

// File: verilog/cache_top.sv
`default_nettype none
`include "cache_settings.svh"

module cache_top (
	input wire logic wclk,
	input wire logic rst,
	input wire logic rd_req,
	input wire cache_pkg::adr_t rd_adr,
	input wire logic ld_req,
	input wire cache_pkg::adr_t ld_adr,
	input wire cache_pkg::line_t ld_dat,
	input wire logic wr_req,
	input wire cache_pkg::adr_t wr_adr,
	input wire cache_pkg::sel_t wr_sel,
	input wire cache_pkg::line_t wr_dat,
	input wire logic inv,
	input wire cache_pkg::adr_t inv_adr,
	output logic rd_ack,
	output cache_pkg::line_t rd_dat,
	output logic rd_miss,
	output cache_pkg::adr_t miss_adr,
	output logic wr_ack
);

	import cache_pkg::*;

	// read channel side
	index_t rd_index;
	set_word_t rd_word;
	way_vec_t rd_valid;
	// update side
	index_t upd_rd_index;
	set_word_t upd_word;
	way_vec_t upd_valid;
	// shared write into both RAM copies and the valid bits
	logic ram_we;
	index_t ram_index;
	set_word_t ram_word;
	logic ld_we;
	logic hit_we;
	way_vec_t hit_way;

	read_port u_read (
		.wclk(wclk), .rst(rst), .rd_req(rd_req), .rd_adr(rd_adr),
		.rd_word(rd_word), .rd_valid(rd_valid), .rd_index(rd_index),
		.rd_ack(rd_ack), .rd_dat(rd_dat), .rd_miss(rd_miss), .miss_adr(miss_adr)
	);

	line_update u_update (
		.wclk(wclk), .rst(rst), .ld_req(ld_req), .ld_adr(ld_adr), .ld_dat(ld_dat),
		.wr_req(wr_req), .wr_adr(wr_adr), .wr_sel(wr_sel), .wr_dat(wr_dat),
		.upd_word(upd_word), .upd_valid(upd_valid), .upd_rd_index(upd_rd_index),
		.ram_we(ram_we), .ram_index(ram_index), .ram_word(ram_word),
		.ld_we(ld_we), .hit_we(hit_we), .hit_way(hit_way), .wr_ack(wr_ack)
	);

	valid_array u_valid (
		.wclk(wclk), .rst(rst), .ld_we(ld_we), .hit_we(hit_we), .hit_way(hit_way),
		.upd_index(ram_index), .inv(inv), .inv_index(adr_index(inv_adr)),
		.rd_index(rd_index), .upd_rd_index(upd_rd_index),
		.rd_valid(rd_valid), .upd_valid(upd_valid)
	);

	// two copies with the same contents, one per reader
	set_ram rd_ram (
		.wclk(wclk), .we(ram_we), .wr_index(ram_index), .wr_word(ram_word),
		.rd_index(rd_index), .rd_word(rd_word)
	);

	set_ram upd_ram (
		.wclk(wclk), .we(ram_we), .wr_index(ram_index), .wr_word(ram_word),
		.rd_index(upd_rd_index), .rd_word(upd_word)
	);

endmodule

`default_nettype wire

// File: bench/tb_cache.sv
`default_nettype none
`include "cache_settings.svh"

module tb_cache;

	localparam int ADR_W = `CACHE_ADR_W;
	localparam int OFS_W = `CACHE_OFS_W;
	localparam int IDX_W = `CACHE_IDX_W;
	localparam int TAG_W = `CACHE_TAG_W;
	localparam int WAYS = `CACHE_WAYS;
	localparam int SETS = `CACHE_SETS;
	localparam int LINE_BYTES = `CACHE_LINE_BYTES;
	localparam int LINE_W = `CACHE_LINE_BYTES * 8;
	localparam int GAP = `CACHE_UPD_GAP;

	// sizes of the test sequences
	localparam int N_RAND = 16;
	localparam int N_LINES = 4;
	localparam int N_OFS = 3;
	localparam int N_EVICT = 5;
	localparam int N_MIX = 16;
	localparam int DRAIN = 4;
	localparam int EVICT_SET = 40;

	// every load or write takes GAP cycles and every read or invalidate one cycle
	localparam int TEST_CYCLES = 3 + N_RAND + N_LINES * (GAP + N_OFS) + N_EVICT * (GAP + 1)
		+ (2 * GAP + 3) + (1 + N_EVICT + N_LINES) + N_MIX + DRAIN;
	localparam int CYCLE_LIMIT = TEST_CYCLES + 100;

	logic wclk;
	logic rst;
	logic rd_req;
	logic [ADR_W-1:0] rd_adr;
	logic ld_req;
	logic [ADR_W-1:0] ld_adr;
	logic [LINE_W-1:0] ld_dat;
	logic wr_req;
	logic [ADR_W-1:0] wr_adr;
	logic [LINE_BYTES-1:0] wr_sel;
	logic [LINE_W-1:0] wr_dat;
	logic inv;
	logic [ADR_W-1:0] inv_adr;
	logic rd_ack;
	logic [LINE_W-1:0] rd_dat;
	logic rd_miss;
	logic [ADR_W-1:0] miss_adr;
	logic wr_ack;

	cache_top i_dut (
		.wclk(wclk), .rst(rst), .rd_req(rd_req), .rd_adr(rd_adr),
		.ld_req(ld_req), .ld_adr(ld_adr), .ld_dat(ld_dat),
		.wr_req(wr_req), .wr_adr(wr_adr), .wr_sel(wr_sel), .wr_dat(wr_dat),
		.inv(inv), .inv_adr(inv_adr), .rd_ack(rd_ack), .rd_dat(rd_dat),
		.rd_miss(rd_miss), .miss_adr(miss_adr), .wr_ack(wr_ack)
	);

	// ==========================================================================
	// reference model state and expectation queues
	// ==========================================================================

	logic [TAG_W-1:0] m_tag [SETS][WAYS];
	logic [LINE_W-1:0] m_line [SETS][WAYS];
	bit m_valid [SETS][WAYS];

	// one entry per read in flight with the oldest request at the front
	int rd_due [$];
	bit rd_hit [$];
	logic [LINE_W-1:0] rd_line [$];
	logic [ADR_W-1:0] rd_exp_adr [$];
	string rd_name [$];
	int wr_due [$];
	string wr_name [$];

	logic [ADR_W-1:0] line_adr [N_LINES];
	logic [31:0] seed = 32'h37f0ae7a;
	string test_name = "reset";
	int cycle = 0;
	int errors = 0;
	int checks = 0;

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [ADR_W-1:0] make_adr(input int tag, input int set,
		input int ofs);
		int a;
		a = (tag % (1 << TAG_W)) * SETS * LINE_BYTES + set * LINE_BYTES + ofs % LINE_BYTES;
		return a[ADR_W-1:0];
	endfunction

	// a read hits when some valid way of its set holds the address tag
	function automatic bit lookup(input logic [ADR_W-1:0] adr,
		output logic [LINE_W-1:0] line);
		int set;
		int tag;
		bit hit;
		set = (adr >> OFS_W) % SETS;
		tag = adr >> (OFS_W + IDX_W);
		hit = 1'b0;
		line = '0;
		for (int w = 0; w < WAYS; w++)
			if (!hit && m_valid[set][w] && m_tag[set][w] == tag) begin
				hit = 1'b1;
				line = m_line[set][w];
			end
		return hit;
	endfunction

	task automatic compare(input string name, input logic [LINE_W-1:0] expected,
		input logic [LINE_W-1:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// ==========================================================================
	// stimulus tasks that change inputs 2 time units after the rising edge
	// ==========================================================================

	task automatic next_cycle();
		@(posedge wclk);
		#2;
		rd_req = 1'b0;
		ld_req = 1'b0;
		wr_req = 1'b0;
		inv = 1'b0;
	endtask

	// the DUT samples the request on the next edge and answers two edges later
	task automatic read_line(input logic [ADR_W-1:0] adr);
		logic [LINE_W-1:0] line;
		bit hit;
		next_cycle();
		rd_req = 1'b1;
		rd_adr = adr;
		hit = lookup(adr, line);
		rd_due.push_back(cycle + 3);
		rd_hit.push_back(hit);
		rd_line.push_back(line);
		rd_exp_adr.push_back(adr);
		rd_name.push_back(test_name);
	endtask

	// the new line goes to way 0 and the other ways move down so that way 3 drops out
	task automatic load_line(input logic [ADR_W-1:0] adr, input logic [LINE_W-1:0] dat);
		int set;
		set = (adr >> OFS_W) % SETS;
		next_cycle();
		ld_req = 1'b1;
		ld_adr = adr;
		ld_dat = dat;
		for (int w = WAYS - 1; w > 0; w--) begin
			m_tag[set][w] = m_tag[set][w-1];
			m_line[set][w] = m_line[set][w-1];
			m_valid[set][w] = m_valid[set][w-1];
		end
		m_tag[set][0] = adr >> (OFS_W + IDX_W);
		m_line[set][0] = dat;
		m_valid[set][0] = 1'b1;
		repeat (GAP - 1) next_cycle();
	endtask

	// only a hitting way takes the enabled bytes and a miss changes nothing
	task automatic write_bytes(input logic [ADR_W-1:0] adr, input logic [LINE_BYTES-1:0] sel,
		input logic [LINE_W-1:0] dat);
		int set;
		int tag;
		set = (adr >> OFS_W) % SETS;
		tag = adr >> (OFS_W + IDX_W);
		next_cycle();
		wr_req = 1'b1;
		wr_adr = adr;
		wr_sel = sel;
		wr_dat = dat;
		wr_due.push_back(cycle + 3);
		wr_name.push_back(test_name);
		for (int w = 0; w < WAYS; w++)
			if (m_valid[set][w] && m_tag[set][w] == tag)
				for (int b = 0; b < LINE_BYTES; b++)
					if (sel[b])
						m_line[set][w][b*8 +: 8] = dat[b*8 +: 8];
		repeat (GAP - 1) next_cycle();
	endtask

	task automatic invalidate_set(input logic [ADR_W-1:0] adr);
		int set;
		set = (adr >> OFS_W) % SETS;
		next_cycle();
		inv = 1'b1;
		inv_adr = adr;
		for (int w = 0; w < WAYS; w++)
			m_valid[set][w] = 1'b0;
	endtask

	initial begin
		wclk = 1'b0;
		forever #10 wclk = ~wclk;
	end

	// cycle count for due times and the run limit
	always @(posedge wclk) begin
		cycle = cycle + 1;
		if (cycle > CYCLE_LIMIT) begin
			$display("ERROR: timeout, run did not end within %0d cycles", CYCLE_LIMIT);
			$display("checks: %0d, errors: %0d", checks, errors + 1);
			$display("Simulation failed");
			$finish;
		end
	end

	// ==========================================================================
	// response checker that samples the outputs at the falling edge
	// ==========================================================================

	always @(negedge wclk) begin : check_responses
		int due;
		bit exp_hit;
		logic [LINE_W-1:0] exp_line;
		logic [ADR_W-1:0] exp_adr;
		string name;
		bit answered;
		answered = 1'b0;
		if (!rst) begin
			if (rd_ack && rd_miss) begin
				errors++;
				$display("ERROR: rd_ack and rd_miss are high together at cycle %0d", cycle);
			end
			while (rd_due.size() > 0 && rd_due[0] <= cycle) begin
				due = rd_due.pop_front();
				exp_hit = rd_hit.pop_front();
				exp_line = rd_line.pop_front();
				exp_adr = rd_exp_adr.pop_front();
				name = rd_name.pop_front();
				if (due < cycle || !(rd_ack || rd_miss)) begin
					errors++;
					$display("ERROR: %s read of %h got no answer at cycle %0d",
						name, exp_adr, due);
				end else begin
					answered = 1'b1;
					compare({name, " ack"}, exp_hit, rd_ack);
					if (exp_hit)
						compare({name, " data"}, exp_line, rd_dat);
					else
						compare({name, " miss_adr"}, exp_adr, miss_adr);
				end
			end
			if ((rd_ack || rd_miss) && !answered) begin
				errors++;
				$display("ERROR: read answer at cycle %0d with no read waiting for it", cycle);
			end
			// write acks come whether or not the write hit
			answered = 1'b0;
			while (wr_due.size() > 0 && wr_due[0] <= cycle) begin
				due = wr_due.pop_front();
				name = wr_name.pop_front();
				if (due < cycle || !wr_ack) begin
					errors++;
					$display("ERROR: %s write got no wr_ack at cycle %0d", name, due);
				end else begin
					answered = 1'b1;
				end
			end
			if (wr_ack && !answered) begin
				errors++;
				$display("ERROR: wr_ack at cycle %0d with no write waiting for it", cycle);
			end
		end
	end

	// ==========================================================================
	// test sequence
	// ==========================================================================

	initial begin
		logic [31:0] r;
		logic [ADR_W-1:0] wr_miss_adr;
		rst = 1'b1;
		rd_req = 1'b0;
		rd_adr = '0;
		ld_req = 1'b0;
		ld_adr = '0;
		ld_dat = '0;
		wr_req = 1'b0;
		wr_adr = '0;
		wr_sel = '0;
		wr_dat = '0;
		inv = 1'b0;
		inv_adr = '0;
		for (int s = 0; s < SETS; s++)
			for (int w = 0; w < WAYS; w++) begin
				m_tag[s][w] = '0;
				m_line[s][w] = '0;
				m_valid[s][w] = 1'b0;
			end
		repeat (3) @(posedge wclk);
		#2;
		rst = 1'b0;

		// an empty cache misses everywhere
		test_name = "reset_miss";
		for (int i = 0; i < N_RAND; i++) begin
			r = lcg_next();
			read_line(r[ADR_W-1:0]);
		end

		// one line per set in sets 1 to N_LINES and then reads at several offsets
		test_name = "load_read";
		for (int k = 0; k < N_LINES; k++) begin
			r = lcg_next();
			line_adr[k] = make_adr(r[31:25], k + 1, r[2:0]);
			load_line(line_adr[k], {lcg_next(), lcg_next()});
		end
		for (int k = 0; k < N_LINES; k++)
			for (int j = 0; j < N_OFS; j++) begin
				r = lcg_next();
				if (j == 0)
					read_line(line_adr[k]);
				else
					read_line(make_adr(line_adr[k] >> (OFS_W + IDX_W), k + 1, r[2:0]));
			end

		// five distinct tags in one set push the first one out
		test_name = "evict";
		for (int k = 0; k < N_EVICT; k++)
			load_line(make_adr(k * 17 + 3, EVICT_SET, 0), {lcg_next(), lcg_next()});
		for (int k = 0; k < N_EVICT; k++) begin
			r = lcg_next();
			read_line(make_adr(k * 17 + 3, EVICT_SET, r[2:0]));
		end

		// a write hit merges bytes while a write miss to the same set leaves the line alone
		test_name = "write";
		r = lcg_next();
		write_bytes(line_adr[0], r[LINE_BYTES-1:0] | 1, {lcg_next(), lcg_next()});
		read_line(line_adr[0]);
		r = lcg_next();
		wr_miss_adr = make_adr((line_adr[0] >> (OFS_W + IDX_W)) + 1, 1, r[2:0]);
		write_bytes(wr_miss_adr, r[LINE_BYTES-1:0] | 1, {lcg_next(), lcg_next()});
		read_line(wr_miss_adr);
		read_line(line_adr[0]);

		// the invalidated set goes empty while the loaded lines elsewhere stay
		test_name = "invalidate";
		invalidate_set(make_adr(0, EVICT_SET, 0));
		for (int k = 0; k < N_EVICT; k++)
			read_line(make_adr(k * 17 + 3, EVICT_SET, 0));
		for (int k = 0; k < N_LINES; k++)
			read_line(line_adr[k]);

		// reads every cycle where cached lines alternate with random addresses
		test_name = "back_to_back";
		for (int i = 0; i < N_MIX; i++) begin
			r = lcg_next();
			if (i % 2 == 1)
				read_line(line_adr[(i / 2) % N_LINES]);
			else
				read_line(r[ADR_W-1:0]);
		end

		repeat (DRAIN) next_cycle();
		if (rd_due.size() != 0 || wr_due.size() != 0) begin
			errors++;
			$display("ERROR: %0d reads and %0d writes still unanswered at the end",
				rd_due.size(), wr_due.size());
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+verilog
verilog/cache_pkg.sv
verilog/set_ram.sv
verilog/valid_array.sv
verilog/tag_match.sv
verilog/read_port.sv
verilog/line_update.sv
verilog/cache_top.sv
bench/tb_cache.sv
